// ==== game_sound.f ====
+incdir+.
game_sound_pkg.sv
tick_gen.sv
note_sequencer.sv
tone_gen.sv
game_sound.sv
tb_game_sound.sv

// ==== Makefile ====
SIM = obj_dir/Vtb_game_sound

.PHONY: all run clean

all: run

$(SIM): game_sound.f game_sound_pkg.sv tick_gen.sv note_sequencer.sv tone_gen.sv \
        game_sound.sv tb_game_sound.sv tb_game_sound_tasks.svh
	verilator --binary --assert -Wno-fatal --top-module tb_game_sound -f game_sound.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_game_sound_tasks.svh ====
`ifndef TB_GAME_SOUND_TASKS_SVH
`define TB_GAME_SOUND_TASKS_SVH

// outputs are sampled and inputs driven here just after the rising edge
task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
endtask

task automatic run_cycles(input int n);
    repeat (n) next_cycle();
endtask

task automatic report_value(input string name, input longint expected, input longint actual);
    errors++;
    $display("Error at %0d ns: %s expected %0d, got %0d", $time, name, expected, actual);
endtask

function automatic int rand_below(input int range);
    rng_state = xorshift(rng_state);
    return int'(rng_state % range);
endfunction

// cycles from a strobe r cycles into a tick period until the new pitch shows
function automatic int cycles_to_tick(input int r);
    return TICK_DIV * ((r + TICK_DIV) / TICK_DIV) - r;
endfunction

task automatic pulse_hit(input bit good, input bit bad);
    good_hit_i = good;
    bad_hit_i  = bad;
    next_cycle();
    good_hit_i = 1'b0;
    bad_hit_i  = 1'b0;
endtask

task automatic wait_pitch_change(input game_sound_pkg::note_t from, input int limit,
                                 input bit silent, output int cycles);
    cycles = 0;
    while (pitch_o === from && cycles < limit) begin
        next_cycle();
        cycles++;
        if (silent && pitch_o === from) begin
            checks++;
            if (tone_o !== 1'b0) begin
                report_value("tone_o", 0, tone_o);
            end
        end
    end
    if (pitch_o === from) begin
        errors++;
        $display("Failure at %0d ns: pitch_o did not change within %0d cycles", $time, limit);
    end
endtask

task automatic measure_tone(output int high_len, output int low_len, output int used);
    high_len = 0;
    low_len  = 0;
    used     = 0;
    // line up on a rising edge
    while (tone_o) begin
        next_cycle();
        used++;
    end
    while (!tone_o) begin
        next_cycle();
        used++;
    end
    while (tone_o) begin
        next_cycle();
        high_len++;
    end
    while (!tone_o) begin
        next_cycle();
        low_len++;
    end
    used += high_len + low_len;
endtask

// expects to start on the first cycle of step first
task automatic follow_steps(input int first, input int count);
    int                    s;
    int                    len;
    int                    used;
    int                    seen;
    int                    half;
    int                    high_len;
    int                    low_len;
    game_sound_pkg::note_t note;
    for (s = first; s < first + count; s++) begin
        note = game_sound_pkg::MELODY[s % game_sound_pkg::STEPS];
        len  = (s % 2 == 0) ? NOTE_LEN : REST_LEN;
        used = 0;
        checks++;
        if (pitch_o !== note) begin
            report_value("pitch_o", note, pitch_o);
        end
        if (s < first + count - 1) begin
            if (note != game_sound_pkg::OFF) begin
                half = int'(note) >> PITCH_SHIFT;
                seen = rand_below(len - 5 * half - 8);
                run_cycles(seen);
                measure_tone(high_len, low_len, used);
                used += seen;
                checks += 2;
                if (high_len != half) begin
                    report_value("tone_o high run", half, high_len);
                end
                if (low_len != half) begin
                    report_value("tone_o low run", half, low_len);
                end
            end
            wait_pitch_change(note, len + TICK_DIV, note == game_sound_pkg::OFF, seen);
            checks++;
            if (used + seen != len) begin
                report_value("step length", len, used + seen);
            end
        end
    end
endtask

task automatic reset_and_idle();
    int i;
    int seen;
    for (i = 0; i < RESET_CYCLES + 4; i++) begin
        if (i == RESET_CYCLES) begin
            nrst = 1'b1;
        end
        next_cycle();
        checks += 2;
        if (pitch_o !== game_sound_pkg::OFF) begin
            report_value("pitch_o", game_sound_pkg::OFF, pitch_o);
        end
        if (tone_o !== 1'b0) begin
            report_value("tone_o", 0, tone_o);
        end
    end
    enable_i = 1'b1;
    wait_pitch_change(game_sound_pkg::OFF, 2 * TICK_DIV, 1'b1, seen);
    checks++;
    if (seen != TICK_DIV) begin
        report_value("first tick delay", TICK_DIV, seen);
    end
endtask

// effect runs for len more cycles and then step 0 plays
task automatic finish_effect(input game_sound_pkg::note_t effect, input int len);
    int seen;
    checks += 3;
    if (pitch_o !== effect) begin
        report_value("pitch_o", effect, pitch_o);
    end
    wait_pitch_change(effect, len + TICK_DIV, 1'b0, seen);
    if (seen != len) begin
        report_value("effect length", len, seen);
    end
    if (pitch_o !== game_sound_pkg::MELODY[0]) begin
        report_value("pitch_o", game_sound_pkg::MELODY[0], pitch_o);
    end
endtask

task automatic hit_effect(input bit good, input bit bad, input game_sound_pkg::note_t effect);
    int delay;
    int seen;
    delay = rand_below(4000);
    run_cycles(delay);
    pulse_hit(good, bad);
    wait_pitch_change(game_sound_pkg::MELODY[0], 2 * TICK_DIV, 1'b0, seen);
    checks++;
    if (seen + 1 != cycles_to_tick(delay)) begin
        report_value("hit to effect delay", cycles_to_tick(delay), seen + 1);
    end
    finish_effect(effect, EFFECT_LEN);
endtask

task automatic effect_restart();
    int delay;
    int seen;
    delay = rand_below(TICK_DIV);
    run_cycles(delay);
    pulse_hit(1'b1, 1'b0);
    wait_pitch_change(game_sound_pkg::MELODY[0], 2 * TICK_DIV, 1'b0, seen);
    delay = rand_below(EFFECT_LEN - 2 * TICK_DIV);
    run_cycles(delay);
    pulse_hit(1'b1, 1'b0);
    // full length again from the tick after the second hit
    finish_effect(game_sound_pkg::GOOD_NOTE, cycles_to_tick(delay) - 1 + EFFECT_LEN);
endtask

task automatic enable_gating();
    int delay;
    int hold;
    int seen;
    int i;
    delay = rand_below(4000);
    run_cycles(delay);
    enable_i = 1'b0;
    hold     = 5 * TICK_DIV + rand_below(TICK_DIV);
    for (i = 0; i < hold; i++) begin
        next_cycle();
        checks += 2;
        if (pitch_o !== game_sound_pkg::MELODY[0]) begin
            report_value("pitch_o", game_sound_pkg::MELODY[0], pitch_o);
        end
        if (tone_o !== 1'b0) begin
            report_value("tone_o", 0, tone_o);
        end
    end
    enable_i = 1'b1;
    wait_pitch_change(game_sound_pkg::MELODY[0], NOTE_LEN + TICK_DIV, 1'b0, seen);
    checks++;
    if (seen != NOTE_LEN - delay) begin
        report_value("step length after enable", NOTE_LEN - delay, seen);
    end
    follow_steps(1, 3);
endtask

`endif

// ==== tb_game_sound.sv ====
`timescale 1ns/1ps

module tb_game_sound;

    localparam int TICK_DIV     = 200;
    localparam int PITCH_SHIFT  = 10;
    localparam int RESET_CYCLES = 8;
    localparam int DRIVE_DELAY  = 2;
    localparam int NOTE_LEN     = int'(game_sound_pkg::NOTE_TICKS) * TICK_DIV;
    localparam int REST_LEN     = int'(game_sound_pkg::REST_TICKS) * TICK_DIV;
    localparam int EFFECT_LEN   = int'(game_sound_pkg::EFFECT_TICKS) * TICK_DIV;
    // one melody loop plus the hit and enable tests is about 250000 cycles
    localparam int TIMEOUT_CYCLES = 375000;

    logic                  clk = 1'b0;
    logic                  nrst;
    logic                  enable_i;
    logic                  good_hit_i;
    logic                  bad_hit_i;
    logic                  tone_o;
    game_sound_pkg::note_t pitch_o;

    int          errors;
    int          checks;
    int          cycle_count;
    logic [31:0] rng_state;

    game_sound #(
        .TICK_DIV    (TICK_DIV),
        .PITCH_SHIFT (PITCH_SHIFT)
    ) dut_i (
        .clk        (clk),
        .nrst       (nrst),
        .enable_i   (enable_i),
        .good_hit_i (good_hit_i),
        .bad_hit_i  (bad_hit_i),
        .tone_o     (tone_o),
        .pitch_o    (pitch_o)
    );

    // 20 ns period
    always begin
        #10 clk = !clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    `include "tb_game_sound_tasks.svh"

    initial begin
        nrst       = 1'b0;
        enable_i   = 1'b0;
        good_hit_i = 1'b0;
        bad_hit_i  = 1'b0;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'hf922435d;
        reset_and_idle();
        // full loop that ends back on step 0
        follow_steps(0, game_sound_pkg::STEPS + 1);
        hit_effect(1'b1, 1'b0, game_sound_pkg::GOOD_NOTE);
        hit_effect(1'b0, 1'b1, game_sound_pkg::BAD_NOTE);
        hit_effect(1'b1, 1'b1, game_sound_pkg::GOOD_NOTE);
        effect_restart();
        enable_gating();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("checks run: %0d, errors: %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== game_sound.sv ====
`timescale 1ns/1ps

module game_sound #(
    parameter int unsigned TICK_DIV    = 50000,
    parameter int unsigned PITCH_SHIFT = 0
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  enable_i,
    input  logic                  good_hit_i,
    input  logic                  bad_hit_i,
    output logic                  tone_o,
    output game_sound_pkg::note_t pitch_o
);

    // note length strobe
    logic tick;

    tick_gen #(
        .TICK_DIV (TICK_DIV)
    ) tick_gen_i (
        .clk      (clk),
        .nrst     (nrst),
        .enable_i (enable_i),
        .tick_o   (tick)
    );

    // melody and hit effects drive pitch_o and the tone generator
    note_sequencer note_sequencer_i (
        .clk        (clk),
        .nrst       (nrst),
        .tick_i     (tick),
        .good_hit_i (good_hit_i),
        .bad_hit_i  (bad_hit_i),
        .pitch_o    (pitch_o)
    );

    tone_gen #(
        .PITCH_SHIFT (PITCH_SHIFT)
    ) tone_gen_i (
        .clk      (clk),
        .nrst     (nrst),
        .enable_i (enable_i),
        .pitch_i  (pitch_o),
        .tone_o   (tone_o)
    );

endmodule

// ==== tone_gen.sv ====
`timescale 1ns/1ps

module tone_gen #(
    parameter int unsigned PITCH_SHIFT = 0
) (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  enable_i,
    input  game_sound_pkg::note_t pitch_i,
    output logic                  tone_o
);

    logic [game_sound_pkg::PERIOD_W-1:0] half;
    logic [game_sound_pkg::PERIOD_W-1:0] cnt;
    logic                                phase;
    game_sound_pkg::note_t               pitch_prev;
    logic                                silent;

    // half period in clock cycles
    assign half   = pitch_i >> PITCH_SHIFT;
    assign silent = !enable_i || (pitch_i == game_sound_pkg::OFF);

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cnt        <= '0;
            phase      <= 1'b0;
            pitch_prev <= game_sound_pkg::OFF;
        end else if (silent) begin
            cnt        <= '0;
            phase      <= 1'b0;
            // seen as a change once sound returns
            pitch_prev <= game_sound_pkg::OFF;
        end else begin
            pitch_prev <= pitch_i;
            if (pitch_i != pitch_prev) begin
                // new note starts on the high half
                cnt   <= 1'b1;
                phase <= 1'b1;
            end else if (cnt >= half) begin
                cnt   <= 1'b1;
                phase <= !phase;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign tone_o = phase;

    // the count stays inside the half period while a note holds
    a_cnt_range: assert property (
        @(posedge clk) disable iff (!nrst)
        (!silent && (pitch_i == pitch_prev) && (half != '0))
            |-> ((cnt != '0) && (cnt <= half))
    ) else $error("half period count out of range");

endmodule

// ==== note_sequencer.sv ====
`timescale 1ns/1ps

module note_sequencer (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  tick_i,
    input  logic                  good_hit_i,
    input  logic                  bad_hit_i,
    output game_sound_pkg::note_t pitch_o
);

    typedef struct packed {
        game_sound_pkg::mode_t              mode;
        logic [game_sound_pkg::STEP_W-1:0]  step;
        logic [game_sound_pkg::DUR_W-1:0]   left;
    } seq_t;

    seq_t                              seq_q;
    seq_t                              seq_d;
    game_sound_pkg::note_t             pitch_q;
    game_sound_pkg::note_t             pitch_d;
    logic                              good_pend;
    logic                              bad_pend;
    logic                              good_any;
    logic                              bad_any;
    logic [game_sound_pkg::STEP_W-1:0] step_nxt;

    // a strobe in the tick cycle itself still counts
    assign good_any = good_pend | good_hit_i;
    assign bad_any  = bad_pend | bad_hit_i;
    assign step_nxt = seq_q.step + 1'b1;

    always_comb begin
        seq_d = seq_q;
        if (good_any) begin
            seq_d.mode = game_sound_pkg::MODE_GOOD;
            seq_d.step = '0;
            seq_d.left = game_sound_pkg::EFFECT_TICKS - 1'b1;
        end else if (bad_any) begin
            seq_d.mode = game_sound_pkg::MODE_BAD;
            seq_d.step = '0;
            seq_d.left = game_sound_pkg::EFFECT_TICKS - 1'b1;
        end else begin
            case (seq_q.mode)
                game_sound_pkg::MODE_IDLE: begin
                    seq_d.mode = game_sound_pkg::MODE_MELODY;
                    seq_d.step = '0;
                    seq_d.left = game_sound_pkg::NOTE_TICKS - 1'b1;
                end
                game_sound_pkg::MODE_MELODY: begin
                    if (seq_q.left == '0) begin
                        // step index wraps 31 to 0 by itself
                        seq_d.step = step_nxt;
                        if (step_nxt[0]) begin
                            seq_d.left = game_sound_pkg::REST_TICKS - 1'b1;
                        end else begin
                            seq_d.left = game_sound_pkg::NOTE_TICKS - 1'b1;
                        end
                    end else begin
                        seq_d.left = seq_q.left - 1'b1;
                    end
                end
                default: begin
                    // melody restarts once the effect is over
                    if (seq_q.left == '0) begin
                        seq_d.mode = game_sound_pkg::MODE_MELODY;
                        seq_d.step = '0;
                        seq_d.left = game_sound_pkg::NOTE_TICKS - 1'b1;
                    end else begin
                        seq_d.left = seq_q.left - 1'b1;
                    end
                end
            endcase
        end
    end

    // pitch of the state about to load
    always_comb begin
        case (seq_d.mode)
            game_sound_pkg::MODE_MELODY: pitch_d = game_sound_pkg::MELODY[seq_d.step];
            game_sound_pkg::MODE_GOOD:   pitch_d = game_sound_pkg::GOOD_NOTE;
            game_sound_pkg::MODE_BAD:    pitch_d = game_sound_pkg::BAD_NOTE;
            default:                     pitch_d = game_sound_pkg::OFF;
        endcase
    end

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            seq_q.mode <= game_sound_pkg::MODE_IDLE;
            seq_q.step <= '0;
            seq_q.left <= '0;
            pitch_q    <= game_sound_pkg::OFF;
            good_pend  <= 1'b0;
            bad_pend   <= 1'b0;
        end else if (tick_i) begin
            seq_q     <= seq_d;
            pitch_q   <= pitch_d;
            good_pend <= 1'b0;
            bad_pend  <= 1'b0;
        end else begin
            // hold hits until the next tick
            good_pend <= good_any;
            bad_pend  <= bad_any;
        end
    end

    assign pitch_o = pitch_q;

    // a hit seen at a tick starts its effect with good before bad
    a_good_pitch: assert property (
        @(posedge clk) disable iff (!nrst)
        (tick_i && good_any) |=> (pitch_o == game_sound_pkg::GOOD_NOTE)
    ) else $error("good hit at a tick without the good effect pitch");

    a_bad_pitch: assert property (
        @(posedge clk) disable iff (!nrst)
        (tick_i && bad_any && !good_any) |=> (pitch_o == game_sound_pkg::BAD_NOTE)
    ) else $error("bad hit at a tick without the bad effect pitch");

endmodule

// ==== tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen #(
    parameter int unsigned TICK_DIV = 50000
) (
    input  logic clk,
    input  logic nrst,
    input  logic enable_i,
    output logic tick_o
);

    localparam int unsigned CNT_LAST = TICK_DIV - 1;

    logic [game_sound_pkg::TICK_W-1:0] cnt;
    logic                              at_last;

    assign at_last = (cnt == CNT_LAST[game_sound_pkg::TICK_W-1:0]);

    // holds its value while disabled
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cnt <= '0;
        end else if (enable_i) begin
            if (at_last) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // a parked counter must not repeat the tick
    assign tick_o = enable_i & at_last;

    a_tick_single: assert property (
        @(posedge clk) disable iff (!nrst)
        ((TICK_DIV > 1) && tick_o) |=> !tick_o
    ) else $error("tick_o high on two consecutive cycles");

endmodule

// ==== game_sound_pkg.sv ====
package game_sound_pkg;

    // one note period word
    localparam int PERIOD_W = 19;

    // note periods in clock cycles before scaling with OFF as silence
    typedef enum logic [PERIOD_W-1:0] {
        BFLAT   = 19'd520000,
        BNOTE   = 19'd482500,
        CNOTE   = 19'd460000,
        CSHARP  = 19'd435000,
        DNOTE   = 19'd410000,
        EFLAT   = 19'd385000,
        ENOTE   = 19'd365000,
        FNOTE   = 19'd345000,
        FSHARP  = 19'd325000,
        GNOTE   = 19'd305000,
        GSHARP  = 19'd285000,
        ANOTE   = 19'd265000,
        BFLAT1  = 19'd245000,
        BNOTE1  = 19'd225000,
        CNOTE1  = 19'd205000,
        CSHARP1 = 19'd185000,
        DNOTE1  = 19'd165000,
        EFLAT1  = 19'd145000,
        ENOTE1  = 19'd125000,
        FNOTE1  = 19'd105000,
        FSHARP1 = 19'd85000,
        GNOTE1  = 19'd65000,
        GSHARP1 = 19'd45000,
        ANOTE1  = 19'd25000,
        BFLAT2  = 19'd5000,
        OFF     = 19'd0
    } note_t;

    // melody length and step index width
    localparam int STEPS  = 32;
    localparam int STEP_W = 5;

    // even steps sound, odd steps rest
    localparam note_t MELODY [STEPS] = '{
        GNOTE, OFF, BNOTE, OFF, DNOTE, OFF, BNOTE, OFF,
        GNOTE, OFF, BNOTE, OFF, ENOTE, OFF, BNOTE, OFF,
        DNOTE, OFF, BNOTE, OFF, DNOTE, OFF, BNOTE, OFF,
        DNOTE, OFF, BNOTE, OFF, CNOTE, OFF, BNOTE, OFF
    };

    // step and effect lengths in ticks
    localparam int DUR_W = 5;
    localparam logic [DUR_W-1:0] NOTE_TICKS   = 5'd25;
    localparam logic [DUR_W-1:0] REST_TICKS   = 5'd30;
    localparam logic [DUR_W-1:0] EFFECT_TICKS = 5'd31;

    // hit effect pitches
    localparam note_t GOOD_NOTE = DNOTE1;
    localparam note_t BAD_NOTE  = BFLAT;

    // what the sequencer is playing
    typedef enum logic [1:0] {
        MODE_IDLE,
        MODE_MELODY,
        MODE_GOOD,
        MODE_BAD
    } mode_t;

    // prescaler counter width
    localparam int TICK_W = 16;

endpackage
